// ==== atom_deserializer.sv ====
`timescale 1ns/1ps
`include "pool_config.svh"

module atom_deserializer (
	input  logic            clk,
	input  logic            rst,
	input  logic            i_run,         // Engine is inside a run
	input  logic            i_rd_we,       // DMA data strobe
	input  pool_pkg::word_t i_rd_data,
	input  logic            i_atom_take,   // Sequencer consumes the held atom
	output logic            o_rd_en,       // Level towards the DMA read port
	output logic            o_atom_valid,
	output pool_pkg::atom_t o_atom
);

	localparam int ATOM_W = `POOL_BURST_LEN * `POOL_WORD_W;
	localparam int CNT_W = $clog2(`POOL_BURST_LEN);
	localparam logic [CNT_W-1:0] LAST_WORD = CNT_W'(`POOL_BURST_LEN - 1);

	pool_pkg::atom_t shift_buf;   // Partial atom being gathered
	pool_pkg::atom_t shift_next;
	logic [CNT_W-1:0] word_cnt;   // Words already in shift_buf
	logic             burst_done;

	// Newest word enters on top, so word 0 drifts down to lane 0
	assign shift_next = {i_rd_data, shift_buf[ATOM_W-1:`POOL_WORD_W]};
	assign burst_done = i_rd_we && (word_cnt == LAST_WORD);

	// Shift path
	always_ff @(posedge clk) begin
		if (i_rd_we) begin
			shift_buf <= shift_next;
		end
	end

	// Hold a copy so the next burst can't disturb the lanes' input
	always_ff @(posedge clk) begin
		if (burst_done) begin
			o_atom <= shift_next;
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			word_cnt     <= '0;
			o_atom_valid <= 1'b0;
		end else if (!i_run) begin
			word_cnt     <= '0;   // Idle engine starts every run on a clean burst
			o_atom_valid <= 1'b0;
		end else begin
			if (burst_done) begin
				word_cnt     <= '0;
				o_atom_valid <= 1'b1;  // Full atom held from next cycle
			end else begin
				if (i_rd_we) begin
					word_cnt <= word_cnt + 1'b1;
				end
				if (i_atom_take) begin
					o_atom_valid <= 1'b0;  // Released, reading resumes
				end
			end
		end
	end

	// Back pressure
	// Reading stops as soon as an atom is held and stays off outside a run
	assign o_rd_en = i_run && !o_atom_valid;

endmodule

// ==== flist.f ====
+incdir+.
pool_pkg.sv
atom_deserializer.sv
pool_lane.sv
pool_writeback.sv
pool_sequencer.sv
pool_engine.sv
pool_engine_sva.sv
pool_checker.sv
pool_engine_tb.sv

// ==== pool_checker.sv ====
`timescale 1ns/1ps
`include "pool_config.svh"

module pool_checker (
	input  logic                clk,
	input  logic                rst,
	input  logic                i_start,
	input  pool_pkg::op_t       i_op,
	input  pool_pkg::win_log2_t i_win_log2,
	input  logic [7:0]          i_num_windows,
	input  logic                i_rd_en,
	input  logic                i_rd_we,
	input  pool_pkg::word_t     i_rd_data,
	input  logic                i_wr_en,
	input  logic                i_wr_valid,
	input  pool_pkg::word_t     i_wr_data,
	input  logic                i_done,
	output int                  o_errors,
	output int                  o_tests,
	output int                  o_words
);

	localparam int LANES = `POOL_BURST_LEN;

	string test_name = "none";  // Written by the testbench before each start
	int    lane_acc [LANES];    // Running max or running sum per channel
	int    exp_q [$];           // Expected words, in send order
	bit    in_run;
	bit    avg_mode;
	int    win_atoms;
	int    num_windows;
	int    rd_words;
	int    wr_words;
	int    test_errors;

	// Negedge sampling, inputs and registered outputs are settled here
	always @(negedge clk) begin : watch
		int lane;
		int pos;
		int exp_word;
		if (rst) begin
			in_run = 1'b0;
			o_errors = 0;
			o_tests = 0;
			o_words = 0;
			exp_q.delete();
		end else if (!in_run) begin
			if (i_rd_en || i_wr_en || i_wr_valid) begin
				$display("Error: DMA signals active between runs (rd_en %b wr_en %b wr_valid %b)",
					i_rd_en, i_wr_en, i_wr_valid);
				o_errors++;
			end
			if (i_done) begin
				$display("Error: done pulse outside a run");
				o_errors++;
			end
			if (i_start) begin
				avg_mode = (i_op == pool_pkg::OP_AVEPOOL);
				win_atoms = 1 << i_win_log2;
				num_windows = int'(i_num_windows);
				rd_words = 0;
				wr_words = 0;
				test_errors = 0;
				exp_q.delete();
				in_run = 1'b1;
			end
		end else begin
			if (i_rd_we) begin
				lane = rd_words % LANES;                  // First word of an atom is lane 0
				pos = (rd_words / LANES) % win_atoms;     // Atom position in its window
				if (pos == 0) begin
					lane_acc[lane] = int'(i_rd_data);
				end else if (avg_mode) begin
					lane_acc[lane] += int'(i_rd_data);
				end else if (int'(i_rd_data) > lane_acc[lane]) begin
					lane_acc[lane] = int'(i_rd_data);
				end
				// Window closes with the last lane of its last atom
				if (lane == LANES - 1 && pos == win_atoms - 1) begin
					for (int l = 0; l < LANES; l++) begin
						exp_q.push_back(avg_mode ? lane_acc[l] / win_atoms : lane_acc[l]);
					end
				end
				rd_words++;
			end
			if (i_wr_valid) begin
				o_words++;
				wr_words++;
				if (exp_q.size() == 0) begin
					$display("Error: %s sent word %0d before its window was read", test_name,
						wr_words - 1);
					test_errors++;
					o_errors++;
				end else begin
					exp_word = exp_q.pop_front();
					if (int'(i_wr_data) != exp_word) begin
						$display("** Error %s word %0d: expected %04h actual %04h", test_name,
							wr_words - 1, exp_word[15:0], i_wr_data);
						test_errors++;
						o_errors++;
					end
				end
			end
			if (i_done) begin
				if (wr_words != num_windows * LANES) begin
					$display("Error: %s ended after %0d words instead of %0d", test_name,
						wr_words, num_windows * LANES);
					test_errors++;
					o_errors++;
				end
				$display("Test %s: %0d windows, %0d words, %0d errors, %s", test_name,
					num_windows, wr_words, test_errors, (test_errors == 0) ? "ok" : "fail");
				o_tests++;
				in_run = 1'b0;
			end
		end
	end

endmodule

// ==== pool_config.svh ====
`ifndef POOL_CONFIG_SVH
`define POOL_CONFIG_SVH

// Width of one channel word
`define POOL_WORD_W 16

// Channels per atom, also the number of lanes
`define POOL_BURST_LEN 16

// Largest window is 2**4 atoms
`define POOL_MAX_WIN_LOG2 4

// Op codes as seen on the command input
`define POOL_OP_MAXPOOL 4
`define POOL_OP_AVEPOOL 5

`endif

// ==== pool_engine.sv ====
`timescale 1ns/1ps
`include "pool_config.svh"

module pool_engine (
	input  logic                clk,
	input  logic                rst,
	input  logic                i_start,
	input  pool_pkg::op_t       i_op,
	input  pool_pkg::win_log2_t i_win_log2,
	input  logic [7:0]          i_num_windows,
	input  logic                i_rd_we,
	input  pool_pkg::word_t     i_rd_data,
	input  logic                i_wr_re,
	output logic                o_rd_en,
	output logic                o_wr_en,
	output pool_pkg::word_t     o_wr_data,
	output logic                o_wr_valid,
	output logic                o_done
);

	logic                run;
	logic                atom_valid;
	logic                lane_take;
	logic                lane_first;
	logic                wb_load;
	logic                wb_busy;
	pool_pkg::op_t       lane_op;
	pool_pkg::win_log2_t lane_win_log2;
	pool_pkg::atom_t     atom;           // Held input atom
	pool_pkg::atom_t     results;        // One word per lane

	atom_deserializer u_deser (
		.clk(clk), .rst(rst),
		.i_run(run), .i_rd_we(i_rd_we), .i_rd_data(i_rd_data), .i_atom_take(lane_take),
		.o_rd_en(o_rd_en), .o_atom_valid(atom_valid), .o_atom(atom)
	);

	pool_sequencer u_seq (
		.clk(clk), .rst(rst),
		.i_start(i_start), .i_op(i_op), .i_win_log2(i_win_log2),
		.i_num_windows(i_num_windows), .i_atom_valid(atom_valid),
		.i_wb_busy(wb_busy), .i_wr_valid(o_wr_valid),
		.o_run(run), .o_take(lane_take), .o_first(lane_first), .o_last(),
		.o_wb_load(wb_load), .o_op(lane_op), .o_win_log2(lane_win_log2), .o_done(o_done)
	);

	// One lane per channel of the atom
	for (genvar g = 0; g < `POOL_BURST_LEN; g++) begin : g_lane
		pool_lane u_lane (
			.clk(clk), .rst(rst),
			.i_take(lane_take), .i_first(lane_first),
			.i_op(lane_op), .i_win_log2(lane_win_log2),
			.i_data(atom[g*`POOL_WORD_W +: `POOL_WORD_W]),
			.o_result(results[g*`POOL_WORD_W +: `POOL_WORD_W])
		);
	end

	pool_writeback u_wb (
		.clk(clk), .rst(rst),
		.i_load(wb_load), .i_results(results), .i_wr_re(i_wr_re),
		.o_busy(wb_busy), .o_wr_en(o_wr_en), .o_wr_data(o_wr_data), .o_wr_valid(o_wr_valid)
	);

endmodule

// ==== pool_engine_sva.sv ====
`timescale 1ns/1ps

module pool_engine_sva (
	input logic clk,
	input logic rst,
	input logic i_wr_re,
	input logic i_wr_valid,
	input logic i_wr_en,
	input logic i_rd_en,
	input logic i_start,     // Top-level start pulse
	input logic i_done
);

	int   fail_count;  // Read back by the testbench summary
	logic in_run;      // Between a start pulse and its done pulse

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			in_run <= 1'b0;
		end else if (i_done) begin
			in_run <= 1'b0;
		end else if (i_start) begin
			in_run <= 1'b1;
		end
	end

	// Each word answers a read-enable pulse from the previous cycle
	wr_valid_after_re: assert property (@(posedge clk) disable iff (rst)
		i_wr_valid |-> $past(i_wr_re))
	else begin
		$error("o_wr_valid without i_wr_re on the cycle before");
		fail_count++;
	end

	no_read_outside_run: assert property (@(posedge clk) disable iff (rst)
		i_rd_en |-> in_run)
	else begin
		$error("o_rd_en high outside a run");
		fail_count++;
	end

	done_single_cycle: assert property (@(posedge clk) disable iff (rst)
		i_done |=> !i_done)
	else begin
		$error("o_done held longer than one cycle");
		fail_count++;
	end

	// Nothing may still be pending when the run reports done
	done_all_drained: assert property (@(posedge clk) disable iff (rst)
		i_done |-> !i_wr_en && !i_rd_en)
	else begin
		$error("o_done while the DMA ports are still enabled");
		fail_count++;
	end

endmodule

// ==== pool_engine_tb.sv ====
`timescale 1ns/1ps
`include "pool_config.svh"

module pool_engine_tb;

	localparam int NUM_TESTS = 6;
	localparam int RESET_CYCLES = 16;
	localparam int MARGIN = 400;  // Start, idle gaps and pipeline fill

	// Test table, one entry per column
	string               t_name    [NUM_TESTS] = '{"max_win4", "avg_win16", "max_win1",
	                                               "avg_win1", "avg_slow_write", "max_slow_both"};
	pool_pkg::op_t       t_op      [NUM_TESTS] = '{pool_pkg::OP_MAXPOOL, pool_pkg::OP_AVEPOOL,
	                                               pool_pkg::OP_MAXPOOL, pool_pkg::OP_AVEPOOL,
	                                               pool_pkg::OP_AVEPOOL, pool_pkg::OP_MAXPOOL};
	pool_pkg::win_log2_t t_log2    [NUM_TESTS] = '{3'd2, 3'd4, 3'd0, 3'd0, 3'd1, 3'd3};
	logic [7:0]          t_windows [NUM_TESTS] = '{8'd6, 8'd3, 8'd5, 8'd5, 8'd6, 8'd3};
	int                  t_rd_gap  [NUM_TESTS] = '{0, 0, 1, 0, 0, 2};
	int                  t_wr_gap  [NUM_TESTS] = '{0, 0, 0, 1, 9, 12};  // Long gaps stall reads

	logic                clk = 1'b0;
	logic                rst;
	logic                i_start;
	pool_pkg::op_t       i_op;
	pool_pkg::win_log2_t i_win_log2;
	logic [7:0]          i_num_windows;
	logic                i_rd_we = 1'b0;    // Driven by the DMA read model only
	pool_pkg::word_t     i_rd_data = '0;
	logic                i_wr_re = 1'b0;    // Driven by the DMA write model only
	logic                o_rd_en;
	logic                o_wr_en;
	pool_pkg::word_t     o_wr_data;
	logic                o_wr_valid;
	logic                o_done;

	logic [15:0]         lfsr_state = 16'd20692;
	pool_pkg::word_t     rd_word;
	int                  rd_gap;
	int                  wr_gap;
	int                  rd_wait = 0;
	int                  wr_wait = 0;
	int                  cycle_cnt = 0;
	int                  cycle_limit;
	int                  chk_errors;
	int                  chk_tests;
	int                  chk_words;
	bit                  timed_out = 1'b0;
	bit                  run_ended = 1'b0;

	always #2 clk = ~clk;  // 4 ns period

	pool_engine pool_engine_i (
		.clk(clk), .rst(rst), .i_start(i_start), .i_op(i_op), .i_win_log2(i_win_log2),
		.i_num_windows(i_num_windows), .i_rd_we(i_rd_we), .i_rd_data(i_rd_data),
		.i_wr_re(i_wr_re), .o_rd_en(o_rd_en), .o_wr_en(o_wr_en), .o_wr_data(o_wr_data),
		.o_wr_valid(o_wr_valid), .o_done(o_done)
	);

	pool_checker pool_checker_i (
		.clk(clk), .rst(rst), .i_start(i_start), .i_op(i_op), .i_win_log2(i_win_log2),
		.i_num_windows(i_num_windows), .i_rd_en(o_rd_en), .i_rd_we(i_rd_we),
		.i_rd_data(i_rd_data), .i_wr_en(o_wr_en), .i_wr_valid(o_wr_valid),
		.i_wr_data(o_wr_data), .i_done(o_done),
		.o_errors(chk_errors), .o_tests(chk_tests), .o_words(chk_words)
	);

	bind pool_engine pool_engine_sva pool_engine_sva_i (
		.clk(clk), .rst(rst), .i_wr_re(i_wr_re), .i_wr_valid(o_wr_valid), .i_wr_en(o_wr_en),
		.i_rd_en(o_rd_en), .i_start(i_start), .i_done(o_done)
	);

	// Galois form, taps x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		logic [15:0] n;
		n = s >> 1;
		if (s[0]) begin
			n = n ^ 16'hB400;
		end
		return n;
	endfunction

	task automatic draw_word(output pool_pkg::word_t w);
		for (int b = 0; b < `POOL_WORD_W; b++) begin
			w[b] = lfsr_state[0];  // One step per bit
			lfsr_state = lfsr_next(lfsr_state);
		end
	endtask

	// DMA read side, a word per pulse only while the engine asks
	always begin
		@(posedge clk);
		#0.5;
		if (!rst && o_rd_en && rd_wait == 0) begin
			draw_word(rd_word);
			i_rd_data = rd_word;
			i_rd_we = 1'b1;
			rd_wait = rd_gap;
		end else begin
			i_rd_we = 1'b0;
			if (rd_wait > 0) begin
				rd_wait--;
			end
		end
	end

	// DMA write side
	always begin
		@(posedge clk);
		#0.5;
		if (!rst && o_wr_en && wr_wait == 0) begin
			i_wr_re = 1'b1;
			wr_wait = wr_gap;
		end else begin
			i_wr_re = 1'b0;
			if (wr_wait > 0) begin
				wr_wait--;
			end
		end
	end

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
	end

	initial begin
		rst = 1'b1;
		i_start = 1'b0;
		i_op = pool_pkg::OP_MAXPOOL;
		i_win_log2 = '0;
		i_num_windows = '0;
		rd_gap = 0;
		wr_gap = 0;
		cycle_limit = RESET_CYCLES + MARGIN;
		for (int t = 0; t < NUM_TESTS; t++) begin
			cycle_limit += int'(t_windows[t]) * (1 << t_log2[t]) * `POOL_BURST_LEN *
				(t_rd_gap[t] + t_wr_gap[t] + 2);
		end
		repeat (RESET_CYCLES) @(posedge clk);
		#0.5;
		rst = 1'b0;
		for (int t = 0; t < NUM_TESTS && !timed_out; t++) begin
			repeat (3) @(posedge clk);  // Idle gap between runs
			#0.5;
			pool_checker_i.test_name = t_name[t];
			rd_gap = t_rd_gap[t];
			wr_gap = t_wr_gap[t];
			i_op = t_op[t];
			i_win_log2 = t_log2[t];
			i_num_windows = t_windows[t];
			i_start = 1'b1;
			@(posedge clk);
			#0.5;
			i_start = 1'b0;
			while (!o_done && cycle_cnt < cycle_limit) begin
				@(posedge clk);
				#0.5;
			end
			if (!o_done) begin
				timed_out = 1'b1;
				$display("Timeout: test %s got no done pulse within %0d cycles", t_name[t],
					cycle_limit);
			end
		end
		repeat (4) @(posedge clk);
		run_ended = 1'b1;
		$display("Summary: %0d of %0d tests ended, %0d words checked, %0d errors, %0d sva fails",
			chk_tests, NUM_TESTS, chk_words, chk_errors, pool_engine_i.pool_engine_sva_i.fail_count);
		if (!timed_out && chk_errors == 0 && chk_tests == NUM_TESTS &&
			pool_engine_i.pool_engine_sva_i.fail_count == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

	// Simulation stopped before the summary
	final begin
		if (!run_ended) begin
			$display("Result: FAILED");
		end
	end

endmodule

// ==== pool_lane.sv ====
`timescale 1ns/1ps
`include "pool_config.svh"

module pool_lane (
	input  logic                clk,
	input  logic                rst,
	input  logic                i_take,      // Atom consumed this cycle
	input  logic                i_first,     // First atom of the window
	input  pool_pkg::op_t       i_op,
	input  pool_pkg::win_log2_t i_win_log2,
	input  pool_pkg::word_t     i_data,      // This lane's channel word
	output pool_pkg::word_t     o_result
);

	pool_pkg::acc_t acc;        // Running max or running sum
	pool_pkg::acc_t data_ext;   // Input word widened to the accumulator
	pool_pkg::acc_t acc_shift;  // Sum divided by the window size
	logic           is_avg;

	assign is_avg   = (i_op == pool_pkg::OP_AVEPOOL);
	assign data_ext = pool_pkg::acc_t'(i_data);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			acc <= '0;
		end else if (i_take) begin
			if (i_first) begin
				acc <= data_ext;  // Window opens with a plain load
			end else if (is_avg) begin
				acc <= acc + data_ext;  // Max sum is 16 x 0xFFFF, fits in 20 bits
			end else if (data_ext > acc) begin
				acc <= data_ext;
			end
		end
	end

	// Window is a power of two so the divide is a shift, floor rounding
	assign acc_shift = acc >> i_win_log2;

	// Max mode never sets the upper accumulator bits
	assign o_result = is_avg ? acc_shift[`POOL_WORD_W-1:0] : acc[`POOL_WORD_W-1:0];

endmodule

// ==== pool_pkg.sv ====
`include "pool_config.svh"

package pool_pkg;

	// One channel value, unsigned
	typedef logic [`POOL_WORD_W-1:0] word_t;

	// Lane 0 sits in the low word
	typedef logic [`POOL_BURST_LEN*`POOL_WORD_W-1:0] atom_t;

	// Room for a full window sum of 16 words
	typedef logic [`POOL_WORD_W+`POOL_MAX_WIN_LOG2-1:0] acc_t;

	typedef enum logic [2:0] {
		OP_MAXPOOL = 3'(`POOL_OP_MAXPOOL),
		OP_AVEPOOL = 3'(`POOL_OP_AVEPOOL)
	} op_t;

	typedef logic [2:0] win_log2_t;  // 0 to 4 in use

endpackage

// ==== pool_sequencer.sv ====
`timescale 1ns/1ps
`include "pool_config.svh"

module pool_sequencer (
	input  logic                clk,
	input  logic                rst,
	input  logic                i_start,
	input  pool_pkg::op_t       i_op,
	input  pool_pkg::win_log2_t i_win_log2,
	input  logic [7:0]          i_num_windows,
	input  logic                i_atom_valid,  // Deserializer holds an atom
	input  logic                i_wb_busy,
	input  logic                i_wr_valid,    // Word leaving the writeback
	output logic                o_run,
	output logic                o_take,
	output logic                o_first,
	output logic                o_last,
	output logic                o_wb_load,
	output pool_pkg::op_t       o_op,
	output pool_pkg::win_log2_t o_win_log2,
	output logic                o_done
);

	typedef enum logic [1:0] {S_IDLE, S_BUSY, S_DRAIN} state_t;

	localparam int CNT_W = `POOL_MAX_WIN_LOG2;
	localparam pool_pkg::win_log2_t MAX_LOG2 = pool_pkg::win_log2_t'(`POOL_MAX_WIN_LOG2);

	state_t           state;
	logic [CNT_W-1:0] atom_cnt;     // Atom position inside the window
	logic [CNT_W:0]   win_len;      // Atoms per window
	logic [7:0]       win_cnt;      // Windows fully taken
	logic [7:0]       num_windows;
	logic             start_ok;
	logic             stall;

	// Unknown op or an empty run is dropped
	assign start_ok = i_start && (i_num_windows != 8'd0) &&
		((i_op == pool_pkg::OP_MAXPOOL) || (i_op == pool_pkg::OP_AVEPOOL));

	assign win_len = {{CNT_W{1'b0}}, 1'b1} << o_win_log2;
	assign o_first = (atom_cnt == '0);
	assign o_last  = ({1'b0, atom_cnt} == win_len - 1'b1);

	// Lanes must not close a window while the previous result is unsent
	assign stall  = o_last && (i_wb_busy || o_wb_load);
	assign o_run  = (state == S_BUSY);
	assign o_take = o_run && i_atom_valid && !stall;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state       <= S_IDLE;
			o_op        <= pool_pkg::OP_MAXPOOL;
			o_win_log2  <= '0;
			num_windows <= '0;
			atom_cnt    <= '0;
			win_cnt     <= '0;
			o_wb_load   <= 1'b0;
			o_done      <= 1'b0;
		end else begin
			o_wb_load <= o_take && o_last;  // Lane results are final one cycle later
			o_done    <= 1'b0;
			case (state)
				S_IDLE: begin
					if (start_ok) begin
						o_op        <= i_op;
						o_win_log2  <= (i_win_log2 > MAX_LOG2) ? MAX_LOG2 : i_win_log2;
						num_windows <= i_num_windows;
						atom_cnt    <= '0;
						win_cnt     <= '0;
						state       <= S_BUSY;
					end
				end
				S_BUSY: begin
					if (o_take && o_last) begin
						atom_cnt <= '0;
						win_cnt  <= win_cnt + 8'd1;
						if (win_cnt == num_windows - 8'd1) begin
							state <= S_DRAIN;  // All atoms in, results still to go
						end
					end else if (o_take) begin
						atom_cnt <= atom_cnt + 1'b1;
					end
				end
				S_DRAIN: begin
					// Last word of the last window just went out
					if (i_wr_valid && !i_wb_busy && !o_wb_load) begin
						o_done <= 1'b1;
						state  <= S_IDLE;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

endmodule

// ==== pool_writeback.sv ====
`timescale 1ns/1ps
`include "pool_config.svh"

module pool_writeback (
	input  logic            clk,
	input  logic            rst,
	input  logic            i_load,      // Capture all lane results
	input  pool_pkg::atom_t i_results,
	input  logic            i_wr_re,     // DMA asks for the next word
	output logic            o_busy,      // Words still waiting to go out
	output logic            o_wr_en,
	output pool_pkg::word_t o_wr_data,
	output logic            o_wr_valid
);

	localparam int IDX_W = $clog2(`POOL_BURST_LEN);
	localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(`POOL_BURST_LEN - 1);

	pool_pkg::atom_t  held;      // Result atom being drained
	logic [IDX_W-1:0] word_idx;  // Next lane to send
	logic             busy;
	logic             send;

	// A pulse only counts while there are words left
	assign send = i_wr_re && busy;

	always_ff @(posedge clk) begin
		if (i_load) begin
			held <= i_results;
		end
	end

	// Word register, lane 0 goes out first
	always_ff @(posedge clk) begin
		if (send) begin
			o_wr_data <= held[word_idx*`POOL_WORD_W +: `POOL_WORD_W];
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			busy       <= 1'b0;
			word_idx   <= '0;
			o_wr_valid <= 1'b0;
		end else begin
			o_wr_valid <= 1'b0;  // Single cycle strobe
			if (i_load) begin
				busy     <= 1'b1;
				word_idx <= '0;
			end else if (send) begin
				o_wr_valid <= 1'b1;
				word_idx   <= word_idx + 1'b1;
				if (word_idx == LAST_IDX) begin
					busy <= 1'b0;  // Drops together with the last valid
				end
			end
		end
	end

	assign o_busy  = busy;
	assign o_wr_en = busy;  // DMA write side may pulse while words remain

endmodule

// ==== run.sh ====
#!/bin/sh
# Build the pooling engine testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
	--top-module pool_engine_tb \
	-f flist.f \
	-Mdir obj_dir \
	-o pool_engine_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

sim_out=$(./obj_dir/pool_engine_sim)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if printf '%s\n' "$sim_out" | grep -q "^Result: PASSED$"; then
	exit 0
fi
exit 1
